//--- include/dma_sched_consts.svh
`ifndef DMA_SCHED_CONSTS_SVH
`define DMA_SCHED_CONSTS_SVH

// ------------------------------
// descriptor table
// ------------------------------
`define NUM_SLOTS    8
`define SLOT_W       3

// credit channels, {dir, section}
`define NUM_CHAN     8
`define CREDIT_W     3
`define CREDIT_INIT  2

// ------------------------------
// block sizing
// ------------------------------
`define BLOCK_MAX    63
`define BLOCK_W      6
`define PAGE_W       12   // 4 KiB pages

`endif

//--- hdl/dma_sched_pkg.sv
`include "dma_sched_consts.svh"

package dma_sched_pkg;

  // one table entry, 64 bits
  typedef struct packed {
    logic [2:0]  spare;
    logic        active;
    logic        gen;       // flips on every cpu rewrite
    logic        dir;       // 1 = read from memory
    logic [1:0]  section;
    logic [23:0] len;       // bytes still to move
    logic [31:0] addr;
  } desc_t;

  typedef logic [`SLOT_W-1:0] slot_t;

  // channel = {dir, section}
  typedef logic [$clog2(`NUM_CHAN)-1:0] chan_t;

endpackage

//--- hdl/desc_table.sv
`timescale 1ns/1ps
`include "dma_sched_consts.svh"

module desc_table (
  input  logic                 CLK,
  input  logic                 RST,
  // cpu side
  input  logic                 cpu_read,
  input  logic                 cpu_write,
  input  dma_sched_pkg::slot_t cpu_addr,
  input  dma_sched_pkg::desc_t cpu_wdata,
  output logic                 cpu_ack,
  output dma_sched_pkg::desc_t cpu_rdata,
  // scheduler side
  input  logic                 tbl_rd,
  input  dma_sched_pkg::slot_t tbl_rd_slot,
  input  logic                 tbl_wb,
  input  dma_sched_pkg::slot_t tbl_wb_slot,
  input  dma_sched_pkg::desc_t tbl_wb_data,
  output dma_sched_pkg::desc_t tbl_rd_data
);
  import dma_sched_pkg::*;

  desc_t mem [`NUM_SLOTS];
  logic  cpu_grant;
  logic  wb_gen_ok;

  // scheduler owns the table whenever it touches it
  assign cpu_grant = (cpu_read || cpu_write) && !tbl_rd && !tbl_wb && !cpu_ack;

  // stale writeback if the cpu toggled gen meanwhile
  assign wb_gen_ok = mem[tbl_wb_slot].gen == tbl_wb_data.gen;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      for (int i = 0; i < `NUM_SLOTS; i++)
        mem[i] <= '0;
      cpu_ack <= 1'b0;
    end
    else
    begin
      cpu_ack <= cpu_grant;   // one cycle after grant
      if (tbl_wb && wb_gen_ok)
        mem[tbl_wb_slot] <= tbl_wb_data;
      else if (cpu_grant && cpu_write)
        mem[cpu_addr] <= cpu_wdata;
    end
  end

  // read ports
  always_ff @(posedge CLK)
  begin
    if (tbl_rd)
      tbl_rd_data <= mem[tbl_rd_slot];
    if (cpu_grant && cpu_read)
      cpu_rdata <= mem[cpu_addr];   // held until next cpu read
  end

endmodule

//--- hdl/credit_pool.sv
`timescale 1ns/1ps
`include "dma_sched_consts.svh"

module credit_pool (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic [`NUM_CHAN-1:0] credit_return,
  input  logic                 credit_take,
  input  dma_sched_pkg::chan_t credit_take_chan,
  output logic [`NUM_CHAN-1:0] credit_avail
);
  import dma_sched_pkg::*;

  localparam logic [`CREDIT_W-1:0] CREDIT_RST = `CREDIT_INIT;
  localparam logic [`CREDIT_W-1:0] CREDIT_MAX = '1;

  for (genvar c = 0; c < `NUM_CHAN; c++)
  begin : g_chan
    logic [`CREDIT_W-1:0] count;
    logic                 take;

    assign take = credit_take && (credit_take_chan == chan_t'(c));
    assign credit_avail[c] = count != '0;

    always_ff @(posedge CLK)
    begin
      if (!RST)
        count <= CREDIT_RST;
      else if (credit_return[c] && !take)
      begin
        if (count != CREDIT_MAX)   // saturate
          count <= count + 1'b1;
      end
      else if (take && !credit_return[c])
      begin
        if (count != '0)
          count <= count - 1'b1;
      end
    end
  end

endmodule

//--- hdl/slot_scheduler.sv
`timescale 1ns/1ps
`include "dma_sched_consts.svh"

module slot_scheduler (
  input  logic                 CLK,
  input  logic                 RST,
  // table
  output logic                 tbl_rd,
  output dma_sched_pkg::slot_t tbl_rd_slot,
  output logic                 tbl_wb,
  output dma_sched_pkg::slot_t tbl_wb_slot,
  output dma_sched_pkg::desc_t tbl_wb_data,
  input  dma_sched_pkg::desc_t tbl_rd_data,
  // credits
  input  logic [`NUM_CHAN-1:0] credit_avail,
  output logic                 credit_take,
  output dma_sched_pkg::chan_t credit_take_chan,
  // executor
  output logic                 go,
  output logic [31:0]          blk_addr,
  output logic [`BLOCK_W-1:0]  blk_len,
  output logic                 blk_dir,
  output logic [1:0]           blk_section,
  input  logic                 exec_ready,
  input  logic                 done,
  input  logic [`BLOCK_W-1:0]  count_sent,
  // interrupt
  output logic                 irq,
  output dma_sched_pkg::slot_t irq_slot
);
  import dma_sched_pkg::*;

  localparam logic [`BLOCK_W-1:0] BLK_MAX = `BLOCK_MAX;

  slot_t                ptr;
  logic                 decide;     // second cycle of a visit
  logic                 busy;       // block out at the executor
  chan_t                rd_chan;
  logic                 issue;
  logic [`BLOCK_W-1:0]  first_len;

  slot_t                cur_slot;
  desc_t                cur_desc;
  logic [23:0]          new_len;
  desc_t                wb_desc;

  // ------------------------------
  // visit: read, then decide
  // ------------------------------
  assign tbl_rd      = exec_ready && !busy && !decide;
  assign tbl_rd_slot = ptr;

  assign rd_chan = {tbl_rd_data.dir, tbl_rd_data.section};
  assign issue   = decide && tbl_rd_data.active && credit_avail[rd_chan];

  assign first_len = (tbl_rd_data.len < {{(24-`BLOCK_W){1'b0}}, BLK_MAX}) ?
                     tbl_rd_data.len[`BLOCK_W-1:0] : BLK_MAX;

  // ------------------------------
  // writeback image
  // ------------------------------
  assign new_len = cur_desc.len - {{(24-`BLOCK_W){1'b0}}, count_sent};

  always_comb
  begin
    wb_desc = cur_desc;
    wb_desc.addr   = cur_desc.addr + {{(32-`BLOCK_W){1'b0}}, count_sent};
    wb_desc.len    = new_len;
    wb_desc.active = new_len != '0;   // finished slot goes idle
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      ptr         <= '0;
      decide      <= 1'b0;
      busy        <= 1'b0;
      go          <= 1'b0;
      credit_take <= 1'b0;
      tbl_wb      <= 1'b0;
      irq         <= 1'b0;
    end
    else
    begin
      decide      <= tbl_rd;
      go          <= issue;
      credit_take <= issue;
      tbl_wb      <= busy && done;
      irq         <= busy && done && (new_len == '0);
      if (decide)
        ptr <= ptr + 1'b1;   // round robin, skipped or not
      if (issue)
        busy <= 1'b1;
      else if (tbl_wb)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (issue)
    begin
      cur_slot         <= ptr;
      cur_desc         <= tbl_rd_data;
      credit_take_chan <= rd_chan;
      blk_addr         <= tbl_rd_data.addr;
      blk_len          <= first_len;
      blk_dir          <= tbl_rd_data.dir;
      blk_section      <= tbl_rd_data.section;
    end
    if (done)
    begin
      tbl_wb_slot <= cur_slot;
      tbl_wb_data <= wb_desc;
      irq_slot    <= cur_slot;
    end
  end

endmodule

//--- hdl/block_executor.sv
`timescale 1ns/1ps
`include "dma_sched_consts.svh"

module block_executor (
  input  logic                    CLK,
  input  logic                    RST,
  // command from the scheduler
  input  logic                    go,
  input  logic [31:0]             blk_addr,
  input  logic [`BLOCK_W-1:0]     blk_len,
  input  logic                    blk_dir,
  input  logic [1:0]              blk_section,
  output logic                    exec_ready,
  output logic                    done,
  output logic [`BLOCK_W-1:0]     count_sent,
  // block mover
  output logic                    mv_issue,
  output logic [31-`PAGE_W:0]     mv_page,
  output logic [`PAGE_W-1:0]      mv_start,
  output logic [`BLOCK_W-1:0]     mv_count_req,
  output logic                    mv_dir,
  output logic [1:0]              mv_section,
  input  logic                    mv_done,
  input  logic [`BLOCK_W-1:0]     mv_count_sent
);

  // one-hot state bits
  localparam int S_IDLE  = 0;
  localparam int S_SETUP = 1;
  localparam int S_SIZE  = 2;
  localparam int S_WAIT  = 3;
  localparam int S_DONE  = 4;

  logic [4:0]            state;
  logic                  advance;
  logic [`PAGE_W:0]      end_addr;
  logic [`BLOCK_W-1:0]   page_rest;

  assign exec_ready = state[S_IDLE];
  assign mv_issue   = state[S_SIZE];
  assign done       = state[S_DONE];

  assign advance = (state[S_IDLE] && go) || state[S_SETUP] || state[S_SIZE] ||
                   (state[S_WAIT] && mv_done) || state[S_DONE];

  // carry out of the page offset means the block crosses
  assign end_addr  = {1'b0, mv_start} + {{(`PAGE_W+1-`BLOCK_W){1'b0}}, blk_len};
  assign page_rest = ~mv_start[`BLOCK_W-1:0] + 1'b1;   // bytes to page end

  always_ff @(posedge CLK)
  begin
    if (!RST)
      state <= 5'b00001;
    else if (advance)
      state <= {state[S_WAIT:S_IDLE], state[S_DONE]};   // rotate
  end

  always_ff @(posedge CLK)
  begin
    if (state[S_IDLE] && go)   // page / offset split
    begin
      mv_page    <= blk_addr[31:`PAGE_W];
      mv_start   <= blk_addr[`PAGE_W-1:0];
      mv_dir     <= blk_dir;
      mv_section <= blk_section;
    end
    if (state[S_SETUP])
      mv_count_req <= end_addr[`PAGE_W] ? page_rest : blk_len;
    if (state[S_WAIT] && mv_done)
      count_sent <= mv_count_sent;
  end

endmodule

//--- hdl/dma_sched_top.sv
`timescale 1ns/1ps
`include "dma_sched_consts.svh"

module dma_sched_top (
  input  logic                 CLK,
  input  logic                 RST,
  // cpu
  input  logic                 cpu_read,
  input  logic                 cpu_write,
  input  dma_sched_pkg::slot_t cpu_addr,
  input  dma_sched_pkg::desc_t cpu_wdata,
  output logic                 cpu_ack,
  output dma_sched_pkg::desc_t cpu_rdata,
  // peripherals
  input  logic [`NUM_CHAN-1:0] credit_return,
  // block mover
  output logic                 mv_issue,
  output logic [31-`PAGE_W:0]  mv_page,
  output logic [`PAGE_W-1:0]   mv_start,
  output logic [`BLOCK_W-1:0]  mv_count_req,
  output logic                 mv_dir,
  output logic [1:0]           mv_section,
  input  logic                 mv_done,
  input  logic [`BLOCK_W-1:0]  mv_count_sent,
  // interrupt
  output logic                 irq,
  output dma_sched_pkg::slot_t irq_slot
);
  import dma_sched_pkg::*;

  // ------------------------------
  // internal nets
  // ------------------------------
  logic                tbl_rd, tbl_wb;
  slot_t               tbl_rd_slot, tbl_wb_slot;
  desc_t               tbl_rd_data, tbl_wb_data;
  logic [`NUM_CHAN-1:0] credit_avail;
  logic                credit_take;
  chan_t               credit_take_chan;
  logic                go, exec_ready, done;
  logic [31:0]         blk_addr;
  logic [`BLOCK_W-1:0] blk_len, count_sent;
  logic                blk_dir;
  logic [1:0]          blk_section;

  desc_table     i_desc_table     (.*);
  credit_pool    i_credit_pool    (.*);
  slot_scheduler i_slot_scheduler (.*);
  block_executor i_block_executor (.*);

endmodule

//--- bench/tb_dma_sched.sv
`timescale 1ns/1ps
`include "dma_sched_consts.svh"

module tb_dma_sched;
  import dma_sched_pkg::*;

  localparam int TOTAL_BLOCKS  = 14;
  localparam int CYC_PER_BLOCK = 80;
  localparam int WATCHDOG_CYC  = TOTAL_BLOCKS * CYC_PER_BLOCK + 3000;
  localparam int WAIT_LIMIT    = 400;

  logic                 CLK;
  logic                 RST;
  logic                 cpu_read;
  logic                 cpu_write;
  slot_t                cpu_addr;
  desc_t                cpu_wdata;
  logic                 cpu_ack;
  desc_t                cpu_rdata;
  logic [`NUM_CHAN-1:0] credit_return;
  logic                 mv_issue;
  logic [31-`PAGE_W:0]  mv_page;
  logic [`PAGE_W-1:0]   mv_start;
  logic [`BLOCK_W-1:0]  mv_count_req;
  logic                 mv_dir;
  logic [1:0]           mv_section;
  logic                 mv_done;
  logic [`BLOCK_W-1:0]  mv_count_sent;
  logic                 irq;
  slot_t                irq_slot;

  // mover log and model knobs
  logic [31:0]          req_addr_q [$];
  logic [`BLOCK_W-1:0]  req_len_q [$];
  chan_t                req_chan_q [$];
  slot_t                irq_q [$];
  logic [`BLOCK_W-1:0]  short_by;
  int                   extra_delay;
  logic                 moving;
  logic [31:0]          rnd;
  int                   credit_m [`NUM_CHAN];

  dma_sched_top i_dma_sched_top (.*);

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial
  begin
    #(WATCHDOG_CYC * 8);
    $display("timeout, the tests did not finish in time");
    $display("Checks failed");
    $fatal(1);
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("ERROR %s expected %0h actual %0h", name, exp, act);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic fail_msg(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  // ------------------------------
  // mover and irq models
  // ------------------------------
  initial
  begin
    int delay;
    mv_done = 1'b0;
    mv_count_sent = '0;
    moving = 1'b0;
    forever
    begin
      @(negedge CLK);
      if (mv_issue)
      begin
        req_addr_q.push_back({mv_page, mv_start});
        req_len_q.push_back(mv_count_req);
        req_chan_q.push_back({mv_dir, mv_section});
        moving = 1'b1;
        rnd = xorshift(rnd);
        delay = 3 + int'(rnd % 8) + extra_delay;
        repeat (delay) @(negedge CLK);
        mv_count_sent <= (mv_count_req > short_by) ? mv_count_req - short_by : mv_count_req;
        mv_done <= 1'b1;
        @(negedge CLK);
        mv_done <= 1'b0;
        moving = 1'b0;
      end
    end
  end

  always @(negedge CLK)
    if (irq)
      irq_q.push_back(irq_slot);

  task automatic give_credit(input chan_t ch);
    @(negedge CLK);
    credit_return[ch] = 1'b1;
    @(negedge CLK);
    credit_return[ch] = 1'b0;
    credit_m[ch]++;
  endtask

  task automatic cpu_access(input logic wr, input slot_t slot, input desc_t d);
    int n;
    n = 0;
    @(negedge CLK);
    cpu_read = !wr;
    cpu_write = wr;
    cpu_addr = slot;
    cpu_wdata = d;
    while (!cpu_ack)
    begin
      @(negedge CLK);
      if (++n > WAIT_LIMIT)
        fail_msg("cpu access was never acknowledged");
    end
    cpu_read = 1'b0;
    cpu_write = 1'b0;
  endtask

  task automatic wait_req();
    int n;
    n = 0;
    while (req_addr_q.size() == 0)
    begin
      @(negedge CLK);
      if (++n > WAIT_LIMIT)
        fail_msg("expected mover request never arrived");
    end
  endtask

  task automatic wait_irq(input string name, input slot_t slot);
    int n;
    n = 0;
    while (irq_q.size() == 0)
    begin
      @(negedge CLK);
      if (++n > WAIT_LIMIT)
        fail_msg("expected irq never arrived");
    end
    check({name, " irq slot"}, slot, irq_q.pop_front());
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_cpu_access();
    desc_t d [`NUM_SLOTS];
    for (int s = 0; s < `NUM_SLOTS; s++)
    begin
      rnd = xorshift(rnd);
      d[s] = {rnd, xorshift(rnd)};
      d[s].active = 1'b0;   // keep the scheduler idle
      cpu_access(1'b1, slot_t'(s), d[s]);
    end
    for (int s = 0; s < `NUM_SLOTS; s++)
    begin
      cpu_access(1'b0, slot_t'(s), '0);
      check("cpu_access", d[s], cpu_rdata);
    end
  endtask

  // expected blocks follow from page end, BLOCK_MAX and remaining length
  task automatic run_transfer(input string name, input slot_t slot, input desc_t d,
                              input logic [`BLOCK_W-1:0] short);
    logic [31:0] a;
    logic [23:0] l;
    int          blk;
    int          sent;
    int          n;
    chan_t       ch;
    desc_t       exp_d;
    a = d.addr;
    l = d.len;
    n = 0;
    ch = {d.dir, d.section};
    while (l != 0)
    begin
      blk = `BLOCK_MAX;
      if (int'(l) < blk)
        blk = int'(l);
      if (4096 - int'(a[11:0]) < blk)
        blk = 4096 - int'(a[11:0]);
      sent = (blk > int'(short)) ? blk - int'(short) : blk;
      a += sent;
      l -= 24'(sent);
      n++;
    end
    while (credit_m[ch] < n)
      give_credit(ch);
    short_by = short;
    cpu_access(1'b1, slot, d);
    a = d.addr;
    l = d.len;
    while (l != 0)
    begin
      blk = `BLOCK_MAX;
      if (int'(l) < blk)
        blk = int'(l);
      if (4096 - int'(a[11:0]) < blk)
        blk = 4096 - int'(a[11:0]);
      wait_req();
      check({name, " addr"}, a, req_addr_q.pop_front());
      check({name, " len"}, blk, req_len_q.pop_front());
      check({name, " chan"}, ch, req_chan_q.pop_front());
      sent = (blk > int'(short)) ? blk - int'(short) : blk;
      a += sent;
      l -= 24'(sent);
      credit_m[ch]--;
    end
    wait_irq(name, slot);
    exp_d = d;
    exp_d.addr = a;
    exp_d.len = '0;
    exp_d.active = 1'b0;
    cpu_access(1'b0, slot, '0);
    check({name, " readback"}, exp_d, cpu_rdata);
    short_by = '0;
  endtask

  task automatic test_credits();
    desc_t d3;
    desc_t d4;
    int    c2;
    d3 = '0;
    d3.active = 1'b1;
    d3.section = 2'd2;      // channel 2
    d3.addr = 32'h0000_4000;
    d3.len = 24'd252;       // four full blocks
    d4 = '0;
    d4.active = 1'b1;
    d4.dir = 1'b1;
    d4.section = 2'd1;      // channel 5
    d4.addr = 32'h0000_8000;
    d4.len = 24'd126;
    cpu_access(1'b1, 3'd3, d3);
    cpu_access(1'b1, 3'd4, d4);
    wait_irq("credits other channel", 3'd4);
    repeat (100) @(negedge CLK);
    c2 = 0;
    foreach (req_chan_q[i])
      if (req_chan_q[i] == 3'd2)
        c2++;
    check("credits before return", `CREDIT_INIT, c2);
    for (int r = 0; r < 2; r++)
    begin
      give_credit(3'd2);
      repeat (100) @(negedge CLK);
      c2 = 0;
      foreach (req_chan_q[i])
        if (req_chan_q[i] == 3'd2)
          c2++;
      check("credits after return", `CREDIT_INIT + r + 1, c2);
    end
    wait_irq("credits drained", 3'd3);
    credit_m[2] -= 4;
    credit_m[5] -= 2;
    req_addr_q.delete();
    req_len_q.delete();
    req_chan_q.delete();
  endtask

  task automatic test_gen_race();
    desc_t d;
    desc_t d_new;
    int    n;
    d = '0;
    d.active = 1'b1;
    d.dir = 1'b1;           // channel 4
    d.addr = 32'h0000_3000;
    d.len = 24'd100;
    d_new = '0;
    d_new.gen = 1'b1;
    d_new.addr = 32'h0000_5555;
    d_new.len = 24'd7;
    d_new.spare = 3'b101;
    extra_delay = 30;
    cpu_access(1'b1, 3'd6, d);
    wait_req();
    cpu_access(1'b1, 3'd6, d_new);
    extra_delay = 0;        // long delay only for the block in flight
    n = 0;
    while (moving)
    begin
      @(negedge CLK);
      if (++n > WAIT_LIMIT)
        fail_msg("mover never finished during the generation test");
    end
    repeat (60) @(negedge CLK);
    check("gen_race requests", 1, req_addr_q.size());
    check("gen_race irq", 0, irq_q.size());
    cpu_access(1'b0, 3'd6, '0);
    check("gen_race readback", d_new, cpu_rdata);
    credit_m[4]--;
  endtask

  initial
  begin
    desc_t d;
    rnd = 32'd54002;
    short_by = '0;
    extra_delay = 0;
    RST = 1'b0;
    cpu_read = 1'b0;
    cpu_write = 1'b0;
    cpu_addr = '0;
    cpu_wdata = '0;
    credit_return = '0;
    for (int c = 0; c < `NUM_CHAN; c++)
      credit_m[c] = `CREDIT_INIT;
    repeat (8) @(negedge CLK);
    RST = 1'b1;
    repeat (2) @(negedge CLK);

    test_cpu_access();

    d = '0;
    d.active = 1'b1;
    d.addr = 32'h0000_1000;
    d.len = 24'd40;
    run_transfer("single_block", 3'd1, d, '0);

    d = '0;
    d.active = 1'b1;
    d.section = 2'd1;
    d.addr = 32'h0000_0FF0;
    d.len = 24'd100;
    run_transfer("splitting", 3'd2, d, '0);

    test_credits();

    d = '0;
    d.active = 1'b1;
    d.section = 2'd3;
    d.addr = 32'h0000_2000;
    d.len = 24'd100;
    run_transfer("partial_sends", 3'd5, d, 6'd10);

    test_gen_race();

    $display("All checks passed");
    $finish;
  end

endmodule

//--- files.f
+incdir+include
hdl/dma_sched_pkg.sv
hdl/desc_table.sv
hdl/credit_pool.sv
hdl/slot_scheduler.sv
hdl/block_executor.sv
hdl/dma_sched_top.sv
bench/tb_dma_sched.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it; exit status is the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_dma_sched -f files.f -o sim_dma_sched

./obj_dir/sim_dma_sched
